//--- src/fcnvt_stoh_pkg.sv
// Shared types for the binary32 to binary16 convert pipeline
// Imported by the unpack, round and top modules

package fcnvt_stoh_pkg;

  // Single bias 127 minus half bias 15
  localparam int unsigned EXP_BIAS_DIFF = 112;

  // RISC-V rounding mode encodings, codes 5 to 7 fold to rne
  typedef enum logic [2:0] {
    rm_rne = 3'd0,
    rm_rtz = 3'd1,
    rm_rdn = 3'd2,
    rm_rup = 3'd3,
    rm_rmm = 3'd4
  } fcnvt_rm_e;

  // Operand class after unpack
  typedef enum logic [2:0] {
    cls_zero,
    cls_finite,
    cls_ovf,
    cls_inf,
    cls_qnan,
    cls_snan
  } stoh_class_e;

  // Exception flags, invalid / overflow / underflow / inexact
  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } stoh_flags_t;

  // Stage 1 payload, rebiased and split ready for rounding
  typedef struct packed {
    logic        sign;
    stoh_class_e cls;
    logic [4:0]  exp_h;
    logic [10:0] mant;
    logic        guard;
    logic        sticky;
    logic        tiny;
    fcnvt_rm_e   rm;
  } stoh_unpacked_t;

  // Half result plus its flags
  typedef struct packed {
    logic [15:0] half;
    stoh_flags_t flags;
  } stoh_result_t;

endpackage

//--- src/fcnvt_stoh_sh.sv
// Denormalizing shifter for single operands that land below the half normal range
// Splits the hidden one and fraction into a half subnormal field and lost bits

`timescale 1ns/1ps

module fcnvt_stoh_sh (
  input  logic [7:0]  sh_cnt,
  input  logic [22:0] sh_src,
  output logic [10:0] f_v,
  output logic [24:0] f_x
);

  // Hidden one, fraction, then room for up to 12 shifted-out bits
  logic [35:0] sig_ext;
  logic [35:0] sig_sh;
  logic [3:0]  sh_amt;
  logic        in_range;

  assign sig_ext = {1'b1, sh_src, 12'b0};

  // Exponents 0x65 to 0x70 map to unbiased -26 to -15
  assign in_range = (sh_cnt >= 8'h65) && (sh_cnt <= 8'h70);

  // 0x70 needs one place of shift, 0x65 needs twelve
  assign sh_amt = in_range ? 4'(8'h71 - sh_cnt) : 4'd0;

  assign sig_sh = sig_ext >> sh_amt;

  always_comb begin
    if (in_range) begin
      // Top 11 bits form the half subnormal mantissa
      f_v = sig_sh[35:25];
      // Bit 24 is the guard, the rest feed sticky
      f_x = sig_sh[24:0];
    end else begin
      // Far below the smallest subnormal
      // Nothing kept, guard clear, a single sticky bit
      f_v = 11'b0;
      f_x = {3'b001, 22'b0};
    end
  end

endmodule

//--- src/fcnvt_stoh_unpack.sv
// Unpack stage of the single to half convert
// Classifies the operand and picks the normal path or the denormalizing shifter

`timescale 1ns/1ps

module fcnvt_stoh_unpack import fcnvt_stoh_pkg::*; (
  input  logic [31:0]    src,
  input  fcnvt_rm_e      rm,
  output stoh_unpacked_t unp
);

  logic [7:0]  exp_s;
  logic [22:0] frac_s;
  logic [10:0] f_v;
  logic [24:0] f_x;

  assign exp_s  = src[30:23];
  assign frac_s = src[22:0];

  // Shifter sees every operand, its output is used only on the tiny path
  fcnvt_stoh_sh i_fcnvt_stoh_sh (
    .sh_cnt (exp_s),
    .sh_src (frac_s),
    .f_v    (f_v),
    .f_x    (f_x)
  );

  always_comb begin
    unp      = '0;
    unp.sign = src[31];
    // Reserved codes behave as round to nearest even
    unp.rm   = (rm > rm_rmm) ? rm_rne : rm;

    if (exp_s == 8'hff) begin
      // Infinity or NaN, quiet bit is fraction MSB
      if (frac_s == 23'b0) begin
        unp.cls = cls_inf;
      end else if (frac_s[22]) begin
        unp.cls = cls_qnan;
      end else begin
        unp.cls = cls_snan;
      end
    end else if ((exp_s == 8'h00) && (frac_s == 23'b0)) begin
      unp.cls = cls_zero;
    end else if (exp_s >= 8'h8f) begin
      // Too large even before rounding
      unp.cls = cls_ovf;
    end else if (exp_s >= 8'h71) begin
      // Half normal range
      unp.cls    = cls_finite;
      unp.exp_h  = 5'(exp_s - EXP_BIAS_DIFF);
      unp.mant   = {1'b1, frac_s[22:13]};
      unp.guard  = frac_s[12];
      unp.sticky = |frac_s[11:0];
    end else begin
      // Below 2^-14, single subnormals land here too
      unp.cls    = cls_finite;
      unp.exp_h  = 5'd0;
      unp.mant   = f_v;
      unp.guard  = f_x[24];
      unp.sticky = |f_x[23:0];
      unp.tiny   = 1'b1;
    end
  end

endmodule

//--- src/fcnvt_stoh_round.sv
// Rounding stage of the single to half convert
// Applies the rounding mode, detects overflow and builds the half result and flags

`timescale 1ns/1ps

module fcnvt_stoh_round import fcnvt_stoh_pkg::*; (
  input  stoh_unpacked_t unp,
  output stoh_result_t   res
);

  logic        lost;
  logic        inc;
  logic [11:0] sum;
  logic [5:0]  exp_r;
  logic [9:0]  frac_r;
  logic        ovf;
  logic        to_max;

  assign lost = unp.guard | unp.sticky;

  // Increment decision per mode
  always_comb begin
    case (unp.rm)
      rm_rne:  inc = unp.guard & (unp.sticky | unp.mant[0]);
      rm_rmm:  inc = unp.guard;
      rm_rup:  inc = lost & ~unp.sign;
      rm_rdn:  inc = lost & unp.sign;
      default: inc = 1'b0;
    endcase
  end

  assign sum = {1'b0, unp.mant} + {11'b0, inc};

  always_comb begin
    if (unp.exp_h == 5'd0) begin
      // Subnormal, carry into the hidden bit gives exponent 1
      exp_r  = {5'b0, sum[10]};
      frac_r = sum[9:0];
    end else begin
      // Normal, mantissa wrap bumps the exponent and leaves the fraction zero
      exp_r  = {1'b0, unp.exp_h} + {5'b0, sum[11]};
      frac_r = sum[9:0];
    end
  end

  // Exponent 31 after rounding is out of range
  assign ovf = (unp.cls == cls_ovf) ||
               ((unp.cls == cls_finite) && (exp_r >= 6'd31));

  // Modes that round toward zero for this sign saturate to max finite
  assign to_max = (unp.rm == rm_rtz) ||
                  ((unp.rm == rm_rdn) && !unp.sign) ||
                  ((unp.rm == rm_rup) && unp.sign);

  always_comb begin
    res = '0;
    case (unp.cls)
      cls_zero: begin
        res.half = {unp.sign, 15'b0};
      end
      cls_inf: begin
        res.half = {unp.sign, 15'h7c00};
      end
      cls_qnan: begin
        res.half = 16'h7e00;
      end
      cls_snan: begin
        // Canonical NaN, signaling input is invalid
        res.half     = 16'h7e00;
        res.flags.nv = 1'b1;
      end
      default: begin
        // cls_finite and cls_ovf
        if (ovf) begin
          res.half = to_max ? {unp.sign, 15'h7bff} : {unp.sign, 15'h7c00};
        end else begin
          res.half = {unp.sign, exp_r[4:0], frac_r};
        end
        res.flags.of = ovf;
        res.flags.nx = lost | ovf;
        // Tininess taken before rounding
        res.flags.uf = unp.tiny & (lost | ovf);
      end
    endcase
  end

endmodule

//--- src/fcnvt_stoh_top.sv
// Top level of the single to half convert pipeline
// One operand per cycle on in_vld, result on out_vld after two cycles
// PIPE_OUT = 0 drops the output register for a latency of one

`timescale 1ns/1ps

module fcnvt_stoh_top import fcnvt_stoh_pkg::*; #(
  parameter bit PIPE_OUT = 1'b1
) (
  input  logic         forever_cpuclk,
  input  logic         rst_n,
  input  logic         in_vld,
  input  logic [31:0]  in_src,
  input  fcnvt_rm_e    in_rm,
  output logic         out_vld,
  output stoh_result_t out_res
);

  stoh_unpacked_t unp_d;
  stoh_unpacked_t s1_unp;
  logic           s1_vld;
  stoh_result_t   res_d;

  // Unpack and shift in the input cycle
  fcnvt_stoh_unpack i_fcnvt_stoh_unpack (
    .src (in_src),
    .rm  (in_rm),
    .unp (unp_d)
  );

  // Stage 1 valid
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= in_vld;
    end
  end

  // Stage 1 payload, cleared value decodes as +0 with no flags
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      s1_unp <= '0;
    end else if (in_vld) begin
      s1_unp <= unp_d;
    end
  end

  // Round from the stage 1 register
  fcnvt_stoh_round i_fcnvt_stoh_round (
    .unp (s1_unp),
    .res (res_d)
  );

  if (PIPE_OUT) begin : g_pipe_out
    // Stage 2 result register
    always_ff @(posedge forever_cpuclk or negedge rst_n) begin
      if (!rst_n) begin
        out_vld <= 1'b0;
        out_res <= '0;
      end else begin
        out_vld <= s1_vld;
        if (s1_vld) begin
          out_res <= res_d;
        end
      end
    end
  end else begin : g_comb_out
    // Result straight out of the rounder
    assign out_vld = s1_vld;
    assign out_res = res_d;
  end

endmodule

//--- verification/tb_fcnvt_stoh.sv
// Testbench for the binary32 to binary16 convert pipeline
// Drives weighted random operands and modes on the falling edge and checks
// every result, its flags and its latency against an integer reference model

`timescale 1ns/1ps

module tb_fcnvt_stoh import fcnvt_stoh_pkg::*;;

  localparam int NUM_OPS     = 4000;
  localparam int RESET_CYC   = 16;
  localparam int WATCHDOG_NS = (NUM_OPS + RESET_CYC + 20) * 4;

  logic         forever_cpuclk;
  logic         rst_n;
  logic         in_vld;
  logic [31:0]  in_src;
  fcnvt_rm_e    in_rm;
  logic         out_vld;
  stoh_result_t out_res;

  integer       seed = 87634;
  int           cyc = 0;
  stoh_result_t exp_q[$];
  int           due_q[$];

  fcnvt_stoh_top #(
    .PIPE_OUT (1'b1)
  ) i_fcnvt_stoh_top (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .in_vld         (in_vld),
    .in_src         (in_src),
    .in_rm          (in_rm),
    .out_vld        (out_vld),
    .out_res        (out_res)
  );

  // 4 ns clock
  always #2 forever_cpuclk = ~forever_cpuclk;

  // Rising edge count, used to time each result
  always @(posedge forever_cpuclk) cyc <= cyc + 1;

  task automatic report_failure(input string what);
    $display("%s at %0t ns", what, $time);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  // Exact significand shifted onto the half grid, then rounded
  function automatic stoh_result_t model_convert(input logic [31:0] src,
                                                 input logic [2:0]  rm_code);
    stoh_result_t r;
    logic         sign;
    logic [2:0]   rm;
    logic [63:0]  sig;
    logic [63:0]  kept;
    logic [31:0]  code;
    int           ue;
    int           sh;
    logic         guard;
    logic         sticky;
    logic         inc;
    logic         tiny;
    logic         ovf;
    r    = '0;
    sign = src[31];
    rm   = (rm_code > 3'd4) ? 3'd0 : rm_code;
    if (src[30:23] == 8'hff) begin
      if (src[22:0] == 23'b0) begin
        r.half = {sign, 15'h7c00};
      end else begin
        r.half     = 16'h7e00;
        r.flags.nv = ~src[22];
      end
      return r;
    end
    if (src[30:0] == 31'b0) begin
      r.half = {sign, 15'h0};
      return r;
    end
    // Single subnormals carry no hidden one
    if (src[30:23] == 8'h00) begin
      sig = {41'b0, src[22:0]};
      ue  = -126;
    end else begin
      sig = {40'b0, 1'b1, src[22:0]};
      ue  = int'(src[30:23]) - 127;
    end
    tiny = (ue < -14);
    // Half ulp is 2^(ue-10) when normal, 2^-24 when subnormal
    sh = tiny ? (-1 - ue) : 13;
    if (sh > 40) begin
      sh = 40;
    end
    kept   = sig >> sh;
    guard  = sig[sh-1];
    sticky = (sig & ((64'd1 << (sh - 1)) - 64'd1)) != 64'd0;
    case (rm)
      3'd0:    inc = guard & (sticky | kept[0]);
      3'd2:    inc = (guard | sticky) & sign;
      3'd3:    inc = (guard | sticky) & ~sign;
      3'd4:    inc = guard;
      default: inc = 1'b0;
    endcase
    // Integer half code, a mantissa carry walks into the exponent field
    if (tiny) begin
      code = 32'(kept) + 32'(inc);
    end else begin
      code = 32'((ue + 14) << 10) + 32'(kept) + 32'(inc);
    end
    ovf = (src[30:23] >= 8'h8f) || (code >= 32'h7c00);
    if (ovf) begin
      if ((rm == 3'd1) || ((rm == 3'd2) && !sign) || ((rm == 3'd3) && sign)) begin
        r.half = {sign, 15'h7bff};
      end else begin
        r.half = {sign, 15'h7c00};
      end
    end else begin
      r.half = {sign, code[14:0]};
    end
    r.flags.of = ovf;
    r.flags.nx = guard | sticky | ovf;
    r.flags.uf = tiny & r.flags.nx;
    return r;
  endfunction

  // Weighted operand mix
  task automatic gen_operand(output logic [31:0] op);
    int          pick;
    logic [7:0]  expo;
    logic [22:0] frac;
    pick = {$random(seed)} % 100;
    frac = 23'($random(seed));
    // Ties and exact values
    if ({$random(seed)} % 4 == 0) begin
      frac[11:0] = 12'b0;
    end
    // Mantissa carries
    if ({$random(seed)} % 8 == 0) begin
      frac[22:13] = 10'h3ff;
    end
    if (pick < 40) begin
      expo = 8'h60 + 8'({$random(seed)} % 19);
    end else if (pick < 52) begin
      expo = 8'h71 + 8'({$random(seed)} % 30);
    end else if (pick < 62) begin
      expo = 8'h8c + 8'({$random(seed)} % 5);
    end else if (pick < 67) begin
      expo = 8'h00;
      frac = 23'b0;
    end else if (pick < 72) begin
      expo = 8'hff;
      frac = 23'b0;
    end else if (pick < 76) begin
      expo     = 8'hff;
      frac[22] = 1'b1;
    end else if (pick < 80) begin
      // Signaling NaN needs a nonzero payload
      expo     = 8'hff;
      frac[22] = 1'b0;
      if (frac == 23'b0) begin
        frac[0] = 1'b1;
      end
    end else if (pick < 87) begin
      expo = 8'({$random(seed)} % 101);
    end else begin
      expo = 8'($random(seed));
    end
    op = {1'($random(seed)), expo, frac};
  endtask

  // Outputs are stable at the falling edge
  task automatic check_output();
    stoh_result_t expected;
    int           due;
    if (out_vld) begin
      if (exp_q.size() == 0) begin
        report_failure("Result strobe with no input outstanding");
      end else begin
        expected = exp_q.pop_front();
        due      = due_q.pop_front();
        check_value("out_res.half", 32'(expected.half), 32'(out_res.half));
        check_value("out_res.flags", 32'(expected.flags), 32'(out_res.flags));
        check_value("out_vld cycle", due, cyc);
      end
    end else if ((due_q.size() != 0) && (due_q[0] <= cyc)) begin
      report_failure("Expected result did not appear on its cycle");
    end
  endtask

  initial begin
    logic [31:0] op;
    logic [2:0]  rm_code;
    forever_cpuclk = 1'b0;
    rst_n          = 1'b0;
    in_vld         = 1'b1;
    in_src         = 32'b0;
    in_rm          = rm_rne;

    // Outputs must stay cleared through reset, even with valid held high
    repeat (RESET_CYC) begin
      @(negedge forever_cpuclk);
      check_value("out_vld", 32'd0, 32'(out_vld));
      check_value("out_res", 32'd0, 32'(out_res));
    end
    rst_n  = 1'b1;
    in_vld = 1'b0;

    for (int i = 0; i < NUM_OPS; i++) begin
      @(negedge forever_cpuclk);
      check_output();
      rm_code = 3'($random(seed));
      if ({$random(seed)} % 10 < 8) begin
        gen_operand(op);
        in_vld = 1'b1;
        in_src = op;
        in_rm  = fcnvt_rm_e'(rm_code);
        exp_q.push_back(model_convert(op, rm_code));
        // Presented this cycle, captured in stage 1, out two cycles later
        due_q.push_back(cyc + 2);
      end else begin
        in_vld = 1'b0;
        in_src = $random(seed);
        in_rm  = fcnvt_rm_e'(rm_code);
      end
    end

    @(negedge forever_cpuclk);
    check_output();
    in_vld = 1'b0;
    // Drain, and catch any extra strobe
    repeat (4) begin
      @(negedge forever_cpuclk);
      check_output();
    end

    if (exp_q.size() != 0) begin
      report_failure("Inputs were accepted but their results never came out");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    report_failure("Simulation timed out");
  end

endmodule

//--- flist.f
src/fcnvt_stoh_pkg.sv
src/fcnvt_stoh_sh.sv
src/fcnvt_stoh_unpack.sv
src/fcnvt_stoh_round.sv
src/fcnvt_stoh_top.sv
verification/tb_fcnvt_stoh.sv

//--- Bender.yml
package:
  name: fcnvt_stoh

sources:
  - src/fcnvt_stoh_pkg.sv
  - src/fcnvt_stoh_sh.sv
  - src/fcnvt_stoh_unpack.sv
  - src/fcnvt_stoh_round.sv
  - src/fcnvt_stoh_top.sv
  - target: test
    files:
      - verification/tb_fcnvt_stoh.sv
